/* src/video_pkg.sv */
// -------------------------------------------------------------------------
// shared PPU definitions
// frame geometry constants, STAT mode / register / fetch step encodings,
// CPU register bus request, register config and line position structs
// -------------------------------------------------------------------------

package video_pkg;

	// frame geometry, one clk is one dot
	localparam logic [8:0] DOTS_PER_LINE   = 9'd456;
	localparam logic [7:0] LINES_PER_FRAME = 8'd154;
	localparam logic [7:0] VISIBLE_LINES   = 8'd144;
	localparam logic [7:0] SCREEN_WIDTH    = 8'd160;
	localparam logic [8:0] OAM_SCAN_DOTS   = 9'd80;   // fixed mode 2 length

	// STAT mode field encodings
	typedef enum logic [1:0] {
		HBLANK   = 2'd0,
		VBLANK   = 2'd1,
		OAM_SCAN = 2'd2,
		DRAW     = 2'd3
	} ppu_mode_e;

	// register offsets on the CPU register bus
	typedef enum logic [7:0] {
		LCDC = 8'h40,
		STAT = 8'h41,
		SCY  = 8'h42,
		SCX  = 8'h43,
		LY   = 8'h44,
		LYC  = 8'h45,
		BGP  = 8'h47
	} reg_addr_e;

	// background fetch steps
	typedef enum logic [2:0] {
		MAP_RD,
		DATA0_RD,
		DATA1_RD,
		READY
	} fetch_state_e;

	typedef struct packed {
		logic       sel;
		logic       wr;
		logic [7:0] addr;
		logic [7:0] wdata;
	} cpu_req_t;

	// register state as seen by timing and fetch logic
	typedef struct packed {
		logic       lcd_on;         // LCDC bit 7
		logic       bg_map_sel;     // LCDC bit 3
		logic       tile_data_sel;  // LCDC bit 4
		logic       bg_ena;         // LCDC bit 0
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] bgp;
		logic [3:0] stat_ena;       // LYC, OAM, VBLANK, HBLANK
	} ppu_cfg_t;

	typedef struct packed {
		logic [7:0] ly;
		logic [8:0] dot;
		ppu_mode_e  mode;
		logic       lyc_match;
	} line_pos_t;

endpackage

/* src/video_regs.sv */
// -------------------------------------------------------------------------
// CPU visible PPU registers
// LCDC, STAT enables, SCY, SCX, LYC and BGP storage, LY/LYC compare
// and the combinational read multiplexer
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module video_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  video_pkg::cpu_req_t  cpu_req,
	input  video_pkg::line_pos_t pos,
	output logic [7:0]           cpu_rdata,
	output video_pkg::ppu_cfg_t  cfg,
	output logic                 lyc_match
);

	import video_pkg::*;

	logic [7:0] lcdc;
	logic [3:0] stat_ena;    // STAT bits 6..3
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] lyc;
	logic [7:0] bgp;

	logic       reg_wr;

	assign reg_wr = cpu_req.sel && cpu_req.wr;

	// -------------------------------------------------------------------------
	// register writes
	// -------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			lcdc      <= 8'h00;    // display starts switched off
			stat_ena  <= 4'h0;
			scy       <= 8'h00;
			scx       <= 8'h00;
			lyc       <= 8'h00;
			bgp       <= 8'hfc;
			lyc_match <= 1'b0;
		end else begin
			// compare lands one dot after LY moves
			lyc_match <= (pos.ly == lyc);

			if (reg_wr) begin
				case (cpu_req.addr)
					LCDC:    lcdc     <= cpu_req.wdata;
					STAT:    stat_ena <= cpu_req.wdata[6:3];
					SCY:     scy      <= cpu_req.wdata;
					SCX:     scx      <= cpu_req.wdata;
					LYC:     lyc      <= cpu_req.wdata;
					BGP:     bgp      <= cpu_req.wdata;
					default: ;         // LY is read only
				endcase
			end
		end
	end

	// decoded view for the timing generator and fetcher
	always_comb begin
		cfg.lcd_on        = lcdc[7];
		cfg.tile_data_sel = lcdc[4];
		cfg.bg_map_sel    = lcdc[3];
		cfg.bg_ena        = lcdc[0];
		cfg.scy           = scy;
		cfg.scx           = scx;
		cfg.bgp           = bgp;
		cfg.stat_ena      = stat_ena;
	end

	// -------------------------------------------------------------------------
	// read mux
	// -------------------------------------------------------------------------

	always_comb begin
		case (cpu_req.addr)
			LCDC:    cpu_rdata = lcdc;
			STAT:    cpu_rdata = {1'b1, stat_ena, pos.lyc_match, pos.mode};
			SCY:     cpu_rdata = scy;
			SCX:     cpu_rdata = scx;
			LY:      cpu_rdata = pos.ly;
			LYC:     cpu_rdata = lyc;
			BGP:     cpu_rdata = bgp;
			default: cpu_rdata = 8'hff;    // open bus
		endcase
	end

endmodule

/* src/lcd_timing.sv */
// -------------------------------------------------------------------------
// LCD timing generator
// dot and line counters, STAT mode sequencing, draw start strobe
// and STAT / vblank interrupt levels
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module lcd_timing (
	input  logic                 clk,
	input  logic                 reset,
	input  video_pkg::ppu_cfg_t  cfg,
	input  logic                 lyc_match,
	input  logic                 draw_done,
	output video_pkg::line_pos_t pos,
	output logic                 draw_start,
	output logic                 irq,
	output logic                 vblank_irq
);

	import video_pkg::*;

	logic [8:0] dot_q;    // 0..455
	logic [7:0] ly_q;     // 0..153
	ppu_mode_e  mode_q;

	logic       line_end;
	logic [7:0] ly_next;
	logic       visible;

	assign line_end = (dot_q == DOTS_PER_LINE - 9'd1);
	assign ly_next  = (ly_q == LINES_PER_FRAME - 8'd1) ? 8'd0 : ly_q + 8'd1;

	// -------------------------------------------------------------------------
	// counters and mode FSM
	// -------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset || !cfg.lcd_on) begin
			dot_q      <= 9'd0;
			ly_q       <= 8'd0;
			mode_q     <= HBLANK;
			draw_start <= 1'b0;
		end else begin
			draw_start <= 1'b0;
			if (line_end) begin
				dot_q  <= 9'd0;
				ly_q   <= ly_next;
				mode_q <= (ly_next < VISIBLE_LINES) ? OAM_SCAN : VBLANK;
			end else begin
				dot_q <= dot_q + 9'd1;
				case (mode_q)
					HBLANK: begin
						// first line after switch-on starts in hblank
						if (dot_q == 9'd0 && ly_q < VISIBLE_LINES)
							mode_q <= OAM_SCAN;
					end
					OAM_SCAN: begin
						if (dot_q == OAM_SCAN_DOTS - 9'd1) begin
							mode_q     <= DRAW;
							draw_start <= 1'b1;    // seen at dot 80
						end
					end
					DRAW: begin
						if (draw_done)
							mode_q <= HBLANK;
					end
					default: ;    // vblank runs to line end
				endcase
			end
		end
	end

	// blanked immediately when the display goes off
	always_comb begin
		pos.ly        = cfg.lcd_on ? ly_q : 8'd0;
		pos.dot       = cfg.lcd_on ? dot_q : 9'd0;
		pos.mode      = cfg.lcd_on ? mode_q : HBLANK;
		pos.lyc_match = cfg.lcd_on && lyc_match;
	end

	// -------------------------------------------------------------------------
	// interrupt levels
	// -------------------------------------------------------------------------

	assign visible = (pos.ly < VISIBLE_LINES);

	assign irq = cfg.lcd_on &&
		((cfg.stat_ena[3] && pos.lyc_match) ||
		 (cfg.stat_ena[2] && pos.mode == OAM_SCAN) ||
		 (cfg.stat_ena[1] && pos.mode == VBLANK) ||
		 (cfg.stat_ena[0] && pos.mode == HBLANK && visible));

	assign vblank_irq = (pos.mode == VBLANK);

endmodule

/* src/bg_fetcher.sv */
// -------------------------------------------------------------------------
// background fetcher
// tile map / tile data fetch sequencer, VRAM addressing, fine scroll
// discard, pixel shift register and BGP shade output stage
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module bg_fetcher (
	input  logic                clk,
	input  logic                reset,
	input  video_pkg::ppu_cfg_t cfg,
	input  logic [7:0]          ly,
	input  logic                draw_start,
	input  logic [7:0]          vram_data,
	output logic                vram_rd,
	output logic [12:0]         vram_addr,
	output logic                draw_done,
	output logic                lcd_clkena,
	output logic [1:0]          lcd_data
);

	import video_pkg::*;

	fetch_state_e state;
	logic         phase;       // second dot of a VRAM read
	logic         active;      // between draw_start and draw_done
	logic         warm;        // first tile of the line fetched once already
	logic [7:0]   fetch_x;     // screen x of the tile being fetched
	logic [7:0]   pix_cnt;     // pixels sent to the LCD
	logic [3:0]   shift_cnt;   // pixels left in the shift register
	logic [2:0]   skip;        // fine scroll pixels still to discard

	logic [7:0]   tile;
	logic [7:0]   data0;
	logic [7:0]   data1;
	logic [7:0]   sh0;
	logic [7:0]   sh1;

	logic         clkena_q;
	logic         done_q;
	logic [1:0]   shade_q;

	logic [7:0]   bg_line;
	logic [7:0]   bg_col;
	logic         tile_a12;
	logic         shifting;
	logic         reload;
	logic [1:0]   pix_idx;
	logic [1:0]   shade;

	// -------------------------------------------------------------------------
	// VRAM addressing
	// -------------------------------------------------------------------------

	assign bg_line  = ly + cfg.scy;
	assign bg_col   = fetch_x + cfg.scx;
	assign tile_a12 = cfg.tile_data_sel ? 1'b0 : ~tile[7];    // signed tiles at 0x1000

	always_comb begin
		case (state)
			MAP_RD:   vram_addr = {2'b11, cfg.bg_map_sel, bg_line[7:3], bg_col[7:3]};
			DATA0_RD: vram_addr = {tile_a12, tile, bg_line[2:0], 1'b0};
			default:  vram_addr = {tile_a12, tile, bg_line[2:0], 1'b1};
		endcase
	end

	assign vram_rd = cfg.lcd_on && active && !phase && state != READY;

	// -------------------------------------------------------------------------
	// pixel pipe control
	// -------------------------------------------------------------------------

	assign shifting = active && shift_cnt != 4'd0 && pix_cnt != SCREEN_WIDTH;

	// refill as the last pixel leaves
	assign reload = active && warm && state == READY &&
		(shift_cnt == 4'd0 || (shift_cnt == 4'd1 && shifting));

	assign pix_idx = cfg.bg_ena ? {sh1[7], sh0[7]} : 2'b00;
	assign shade   = cfg.bgp[{pix_idx, 1'b0} +: 2];

	always_ff @(posedge clk) begin
		if (reset || !cfg.lcd_on) begin
			state     <= MAP_RD;
			phase     <= 1'b0;
			active    <= 1'b0;
			warm      <= 1'b0;
			fetch_x   <= 8'd0;
			pix_cnt   <= 8'd0;
			shift_cnt <= 4'd0;
			skip      <= 3'd0;
			clkena_q  <= 1'b0;
			done_q    <= 1'b0;
			shade_q   <= 2'b00;
		end else begin
			clkena_q <= 1'b0;
			done_q   <= clkena_q && pix_cnt == SCREEN_WIDTH;    // after pixel 160

			if (draw_start) begin
				active    <= 1'b1;
				warm      <= 1'b0;
				state     <= MAP_RD;
				phase     <= 1'b0;
				fetch_x   <= 8'd0;
				pix_cnt   <= 8'd0;
				shift_cnt <= 4'd0;
				skip      <= cfg.scx[2:0];
			end else if (active) begin
				// fetch sequencer
				if (state != READY) begin
					phase <= ~phase;
					if (phase) begin
						case (state)
							MAP_RD:   state <= DATA0_RD;
							DATA0_RD: state <= DATA1_RD;
							default:  state <= READY;
						endcase
					end
				end else if (!warm) begin
					warm  <= 1'b1;       // first fetch is thrown away
					state <= MAP_RD;
				end else if (reload) begin
					state   <= MAP_RD;
					fetch_x <= fetch_x + 8'd8;
				end

				if (reload)
					shift_cnt <= 4'd8;
				else if (shifting)
					shift_cnt <= shift_cnt - 4'd1;

				if (shifting) begin
					if (skip != 3'd0) begin
						skip <= skip - 3'd1;
					end else begin
						clkena_q <= 1'b1;
						shade_q  <= shade;
						pix_cnt  <= pix_cnt + 8'd1;
					end
				end

				if (clkena_q && pix_cnt == SCREEN_WIDTH)
					active <= 1'b0;
			end
		end
	end

	// tile bytes and shift register
	always_ff @(posedge clk) begin
		if (active && phase) begin
			case (state)
				MAP_RD:   tile  <= vram_data;
				DATA0_RD: data0 <= vram_data;
				DATA1_RD: data1 <= vram_data;
				default:  ;
			endcase
		end

		if (reload) begin
			sh0 <= data0;
			sh1 <= data1;
		end else if (shifting) begin
			sh0 <= {sh0[6:0], 1'b0};    // msb is the leftmost pixel
			sh1 <= {sh1[6:0], 1'b0};
		end
	end

	assign lcd_clkena = cfg.lcd_on && clkena_q;
	assign lcd_data   = cfg.lcd_on ? shade_q : 2'b00;
	assign draw_done  = cfg.lcd_on && done_q;

endmodule

/* src/video_top.sv */
// -------------------------------------------------------------------------
// PPU background path top level
// register block, LCD timing generator and background fetcher
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module video_top (
	input  logic                clk,
	input  logic                reset,
	input  video_pkg::cpu_req_t cpu_req,
	output logic [7:0]          cpu_rdata,
	output logic                vram_rd,
	output logic [12:0]         vram_addr,
	input  logic [7:0]          vram_data,
	output logic                lcd_on,
	output logic                lcd_clkena,
	output logic [1:0]          lcd_data,
	output logic                irq,
	output logic                vblank_irq
);

	import video_pkg::*;

	ppu_cfg_t  cfg;
	line_pos_t pos;
	logic      lyc_match;
	logic      draw_start;
	logic      draw_done;

	assign lcd_on = cfg.lcd_on;

	video_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.cpu_req   (cpu_req),
		.pos       (pos),
		.cpu_rdata (cpu_rdata),
		.cfg       (cfg),
		.lyc_match (lyc_match)
	);

	// lyc_match comes back inside pos for the STAT read
	lcd_timing u_timing (
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.lyc_match  (lyc_match),
		.draw_done  (draw_done),
		.pos        (pos),
		.draw_start (draw_start),
		.irq        (irq),
		.vblank_irq (vblank_irq)
	);

	bg_fetcher u_fetch (
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.ly         (pos.ly),
		.draw_start (draw_start),
		.vram_data  (vram_data),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.draw_done  (draw_done),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data)
	);

endmodule

/* verification/video_props.sv */
// -------------------------------------------------------------------------
// concurrent assertions on PPU mode sequencing and pixel strobes,
// bound into the top level
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module video_props (
	input logic                 clk,
	input logic                 reset,
	input logic                 lcd_clkena,
	input logic                 vblank_irq,
	input video_pkg::line_pos_t pos
);

	import video_pkg::*;

	// pixels only leave during mode 3
	a_clkena_in_draw: assert property (@(posedge clk) disable iff (reset)
		lcd_clkena |-> pos.mode == DRAW)
		else $error("lcd_clkena outside of mode DRAW");

	a_no_draw_in_vblank: assert property (@(posedge clk) disable iff (reset)
		pos.ly >= VISIBLE_LINES |-> pos.mode != DRAW)
		else $error("mode DRAW on line %0d", pos.ly);

	a_vblank_irq: assert property (@(posedge clk) disable iff (reset)
		vblank_irq == (pos.ly >= VISIBLE_LINES))
		else $error("vblank_irq does not follow lines 144 to 153");

endmodule

bind video_top video_props u_props (
	.clk        (clk),
	.reset      (reset),
	.lcd_clkena (lcd_clkena),
	.vblank_irq (vblank_irq),
	.pos        (pos)
);

/* verification/video_tb.sv */
// -------------------------------------------------------------------------
// PPU background path testbench
// clock and reset, CPU register bus tasks, VRAM model, per frame stimulus
// from the stim file, line / pixel / interrupt monitor and reporting
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module video_tb;

	import video_pkg::*;

	localparam int MAX_RECORDS  = 64;
	localparam int FRAME_CYCLES = 70224;
	localparam int LINE_CYCLES  = 456;

	logic        clk;
	logic        reset;
	cpu_req_t    cpu_req;
	logic [7:0]  cpu_rdata;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data;
	logic        lcd_on;
	logic        lcd_clkena;
	logic [1:0]  lcd_data;
	logic        irq;
	logic        vblank_irq;

	// one entry per stim file record
	logic [7:0] rec_scx [MAX_RECORDS];
	logic [7:0] rec_bgp [MAX_RECORDS];
	logic [7:0] rec_fill [MAX_RECORDS];
	logic [7:0] rec_lyc [MAX_RECORDS];
	logic [7:0] rec_stat [MAX_RECORDS];
	logic [7:0] rec_ly [MAX_RECORDS];
	int         num_records;

	// record under test
	logic [7:0] cur_scx;
	logic [7:0] cur_scy;
	logic [7:0] cur_bgp;
	logic [7:0] cur_fill;
	logic [7:0] cur_lyc;
	logic [3:0] cur_ena;    // STAT bits 6..3

	int errors;
	int checks;
	int cycle;
	int cycle_limit;

	// monitor state
	logic       on_q;
	logic       first_line;
	logic [7:0] prev_ly;
	int         line_cycles;
	int         pix_cnt;
	int         oam_cnt;
	int         lines_seen;
	int         wraps_seen;
	int         map_reads;

	logic [7:0] ly;
	logic [8:0] dot;
	ppu_mode_e  mode;

	assign ly   = u_video_top.pos.ly;
	assign dot  = u_video_top.pos.dot;
	assign mode = u_video_top.pos.mode;

	video_top u_video_top (
		.clk        (clk),
		.reset      (reset),
		.cpu_req    (cpu_req),
		.cpu_rdata  (cpu_rdata),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data),
		.lcd_on     (lcd_on),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data),
		.irq        (irq),
		.vblank_irq (vblank_irq)
	);

	always #4 clk = ~clk;

	// every VRAM byte is the fill byte
	always @(negedge clk) begin
		if (vram_rd) begin
			vram_data <= cur_fill;
			check_vram_addr();
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle_limit != 0 && cycle >= cycle_limit) begin
			$display("timeout after %0d cycles, the run did not finish", cycle);
			$display("Test FAILED");
			$finish;
		end
	end

	// -------------------------------------------------------------------------
	// helpers
	// -------------------------------------------------------------------------

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		checks = checks + 1;
		if (actual !== expected) begin
			errors = errors + 1;
			$display("** Error at %0t: %s, got %0h expected %0h", $time, msg, actual,
				expected);
		end
	endtask

	// colour 3 where the fill bit is set, else colour 0
	function automatic logic [1:0] expected_shade(input int x);
		int bitpos;
		bitpos = 7 - ((x + cur_scx) % 8);
		return cur_fill[bitpos] ? cur_bgp[7:6] : cur_bgp[1:0];
	endfunction

	// early sample falls in mode 2 or vblank, late one in hblank or vblank
	function automatic logic expected_irq(input logic [7:0] line, input logic early);
		logic vis;
		vis = line < VISIBLE_LINES;
		return (cur_ena[3] && line == cur_lyc) ||
			(cur_ena[2] && vis && early) ||
			(cur_ena[1] && !vis) ||
			(cur_ena[0] && vis && !early);
	endfunction

	// LCDC 0x91 puts the map at 0x1800 and unsigned tile data at 0x0000
	task automatic check_vram_addr();
		logic [7:0] bg_y;
		bg_y = ly + cur_scy;
		if (vram_addr[12:11] == 2'b11) begin
			check(vram_addr[10:5], {1'b0, bg_y[7:3]}, "tile map row");
			if (map_reads == 0)
				check(vram_addr[4:0], cur_scx[7:3], "first tile map column");
			map_reads = map_reads + 1;
		end else begin
			check(vram_addr[12:1], {1'b0, cur_fill, bg_y[2:0]}, "tile data address");
		end
	endtask

	// bus tasks start and end on a falling edge
	task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
		cpu_req.sel   = 1'b1;
		cpu_req.wr    = 1'b1;
		cpu_req.addr  = addr;
		cpu_req.wdata = data;
		@(negedge clk);
		cpu_req = '0;
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
		cpu_req.sel   = 1'b1;
		cpu_req.wr    = 1'b0;
		cpu_req.addr  = addr;
		cpu_req.wdata = 8'h00;
		@(negedge clk);
		data    = cpu_rdata;
		cpu_req = '0;
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [7:0] expected,
		input string what);
		logic [7:0] data;
		bus_read(addr, data);
		check(data, expected, what);
	endtask

	task automatic wait_for_ly(input logic [7:0] target);
		logic [7:0] val;
		cpu_req.sel  = 1'b1;
		cpu_req.wr   = 1'b0;
		cpu_req.addr = LY;
		do begin
			@(negedge clk);
			val = cpu_rdata;
		end while (val != target);
		cpu_req = '0;
	endtask

	task automatic load_stimulus();
		int         fd;
		int         n;
		string      line;
		logic [7:0] v_scx;
		logic [7:0] v_bgp;
		logic [7:0] v_fill;
		logic [7:0] v_lyc;
		logic [7:0] v_stat;
		logic [7:0] v_ly;
		num_records = 0;
		fd = $fopen("verification/video_stim.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd) && num_records < MAX_RECORDS) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h", v_scx, v_bgp, v_fill, v_lyc,
						v_stat, v_ly);
					if (n == 6) begin
						rec_scx[num_records]  = v_scx;
						rec_bgp[num_records]  = v_bgp;
						rec_fill[num_records] = v_fill;
						rec_lyc[num_records]  = v_lyc;
						rec_stat[num_records] = v_stat;
						rec_ly[num_records]   = v_ly;
						num_records = num_records + 1;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// -------------------------------------------------------------------------
	// register and frame tests
	// -------------------------------------------------------------------------

	task automatic test_registers();
		read_expect(LCDC, 8'h00, "LCDC reset value");
		read_expect(STAT, 8'h80, "STAT reset value");
		read_expect(SCY, 8'h00, "SCY reset value");
		read_expect(SCX, 8'h00, "SCX reset value");
		read_expect(LY, 8'h00, "LY reset value");
		read_expect(LYC, 8'h00, "LYC reset value");
		read_expect(BGP, 8'hfc, "BGP reset value");
		read_expect(8'h46, 8'hff, "unmapped 0x46");
		read_expect(8'h00, 8'hff, "unmapped 0x00");

		bus_write(SCY, 8'ha5);
		read_expect(SCY, 8'ha5, "SCY readback");
		bus_write(SCX, 8'h3c);
		read_expect(SCX, 8'h3c, "SCX readback");
		bus_write(LYC, 8'h91);
		read_expect(LYC, 8'h91, "LYC readback");
		bus_write(BGP, 8'h1b);
		read_expect(BGP, 8'h1b, "BGP readback");
		bus_write(STAT, 8'h78);
		read_expect(STAT, 8'hf8, "STAT enables readback");
		bus_write(STAT, 8'h87);    // only bits 6..3 are writable
		read_expect(STAT, 8'h80, "STAT read only bits");
		bus_write(LCDC, 8'h7f);
		read_expect(LCDC, 8'h7f, "LCDC readback with display off");
		bus_write(LY, 8'h55);
		read_expect(LY, 8'h00, "LY ignores writes");
	endtask

	task automatic run_record(input int i);
		int         start;
		logic [7:0] stat_exp;
		cur_scx  = rec_scx[i];
		cur_scy  = 8'(i * 37);
		cur_bgp  = rec_bgp[i];
		cur_fill = rec_fill[i];
		cur_lyc  = rec_lyc[i];
		cur_ena  = rec_stat[i][6:3];

		bus_write(SCY, cur_scy);
		bus_write(SCX, cur_scx);
		bus_write(BGP, cur_bgp);
		bus_write(LYC, cur_lyc);
		bus_write(STAT, rec_stat[i]);
		read_expect(BGP, cur_bgp, "BGP before switch-on");

		bus_write(LCDC, 8'h91);
		start = cycle;
		check(lcd_on, 1'b1, "lcd_on after switch-on");

		wait_for_ly(cur_lyc);
		repeat (10) @(negedge clk);
		stat_exp = {1'b1, cur_ena, 1'b1, (cur_lyc < VISIBLE_LINES) ? 2'd2 : 2'd1};
		read_expect(STAT, stat_exp, "STAT on the LYC line");
		read_expect(LY, rec_ly[i], "LY at readback");

		while (cycle - start < FRAME_CYCLES + LINE_CYCLES)
			@(negedge clk);
		check(wraps_seen, 1, "LY wraps once per frame");
		check(lines_seen >= 154, 1, "lines seen in one frame plus one line");

		// display off, counters cleared
		bus_write(LCDC, 8'h11);
		check(lcd_on, 1'b0, "lcd_on after switch-off");
		read_expect(LY, 8'h00, "LY after switch-off");
		read_expect(STAT, {1'b1, cur_ena, 3'b000}, "STAT after switch-off");
		repeat (600) @(negedge clk);
	endtask

	// -------------------------------------------------------------------------
	// line, pixel and interrupt monitor
	// -------------------------------------------------------------------------

	always @(negedge clk) begin
		logic [7:0] ly_want;
		if (cycle >= 1) begin
			if (lcd_on) begin
				if (!on_q) begin
					line_cycles = 0;    // dot 0 of line 0
					pix_cnt     = 0;
					oam_cnt     = 0;
					lines_seen  = 0;
					wraps_seen  = 0;
					map_reads   = 0;
					first_line  = 1'b1;
					prev_ly     = ly;
				end
				if (ly != prev_ly) begin
					ly_want = (prev_ly == 8'd153) ? 8'd0 : prev_ly + 8'd1;
					check(line_cycles, LINE_CYCLES, "line length in clocks");
					check(ly, ly_want, "LY sequence");
					if (prev_ly < VISIBLE_LINES) begin
						check(pix_cnt, 160, "pixels per visible line");
						if (!first_line)
							check(oam_cnt, 80, "OAM scan length");
					end
					if (ly == 8'd0)
						wraps_seen = wraps_seen + 1;
					lines_seen  = lines_seen + 1;
					line_cycles = 0;
					pix_cnt     = 0;
					oam_cnt     = 0;
					map_reads   = 0;
					first_line  = 1'b0;
				end
				line_cycles = line_cycles + 1;
				prev_ly     = ly;
				check(dot, line_cycles - 1, "dot counter");
				if (mode == OAM_SCAN)
					oam_cnt = oam_cnt + 1;

				check(mode == VBLANK, ly >= VISIBLE_LINES, "VBLANK on lines 144 to 153");
				check(vblank_irq, ly >= VISIBLE_LINES, "vblank_irq level");
				if (cur_ena == 4'h0)
					check(irq, 1'b0, "irq with all enables clear");
				if (line_cycles == 40)
					check(irq, expected_irq(ly, 1'b1), "irq early in line");
				if (line_cycles == 400)
					check(irq, expected_irq(ly, 1'b0), "irq late in line");

				if (lcd_clkena) begin
					check(mode == DRAW, 1'b1, "pixel strobe while drawing");
					check(ly < VISIBLE_LINES, 1'b1, "pixel strobe on a visible line");
					check(pix_cnt < 160, 1'b1, "at most 160 pixels per line");
					check(lcd_data, expected_shade(pix_cnt), "pixel shade");
					pix_cnt = pix_cnt + 1;
				end
			end else begin
				check(lcd_clkena, 1'b0, "lcd_clkena with display off");
				check(vram_rd, 1'b0, "vram_rd with display off");
				check(irq, 1'b0, "irq with display off");
				check(vblank_irq, 1'b0, "vblank_irq with display off");
				check(lcd_data, 2'b00, "lcd_data with display off");
			end
			on_q = lcd_on;
		end
	end

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		cpu_req     = '0;
		vram_data   = 8'h00;
		on_q        = 1'b0;
		map_reads   = 0;
		cur_scx     = 8'h00;
		cur_scy     = 8'h00;
		cur_bgp     = 8'hfc;
		cur_fill    = 8'h00;
		cur_lyc     = 8'h00;
		cur_ena     = 4'h0;
		cycle_limit = 0;
		load_stimulus();
		if (num_records <= 0) begin
			$display("could not read any records from verification/video_stim.txt");
			$display("Test FAILED");
			$finish;
		end else begin
			cycle_limit = num_records * 75000 + 1000;
			repeat (4) @(negedge clk);
			reset = 1'b0;
			test_registers();
			for (int i = 0; i < num_records; i++)
				run_record(i);
			$display("%0d errors in %0d checks over %0d records", errors, checks,
				num_records);
			if (errors == 0)
				$display("Test OK");
			else
				$display("Test FAILED");
			$finish;
		end
	end

endmodule

/* verification/video_stim.txt */
# scx bgp fill lyc stat ly_at_readback, all hex
# fill is returned for every VRAM read, stat is the byte written to STAT
00 e4 f0 00 40 00
03 e4 aa 05 40 05
07 1b 81 2a 00 2a
01 fc 55 40 48 40
05 e4 0f 63 50 63
02 27 cc 8f 60 8f
06 93 3c 90 40 90
04 e4 ff 99 10 99
00 1b 00 0a 00 0a
08 e4 a5 11 78 11
0b 6c 5a 47 40 47
0f d2 e7 20 08 20
12 e4 18 01 20 01
27 39 c3 77 40 77
80 e4 96 91 50 91
fd 4e 7e 3b 40 3b

/* verilog.f */
src/video_pkg.sv
src/video_regs.sv
src/lcd_timing.sv
src/bg_fetcher.sv
src/video_top.sv
verification/video_props.sv
verification/video_tb.sv

/* Makefile */
TOP := video_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
